// File: hdl/valu_pkg.sv
`default_nettype none

package valu_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int VLEN_BITS     = 128;
    localparam int MAX_REGS      = 4;
    localparam int ELEM_MAX_BITS = 32;

    // widest element, also the container for narrower ones
    typedef logic [ELEM_MAX_BITS-1:0] elem_t;
    typedef logic [VLEN_BITS-1:0] reg_t;
    // register 0 sits in the low bits
    typedef logic [MAX_REGS*VLEN_BITS-1:0] reg_group_t;
    typedef logic [1:0] pass_t;
    typedef logic [1:0] reg_idx_t;
    // register or group count, 1 to 4
    typedef logic [2:0] cnt_t;

    ////////////////////////////////////////////////////////////
    // command encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_min  = 4'd8,
        op_max  = 4'd9,
        op_minu = 4'd10,
        op_maxu = 4'd11
    } alu_op_t;

    typedef enum logic [1:0] {
        sew_8  = 2'd0,
        sew_16 = 2'd1,
        sew_32 = 2'd2
    } sew_t;

    typedef enum logic [1:0] {
        lmul_1 = 2'd0,
        lmul_2 = 2'd1,
        lmul_4 = 2'd2
    } lmul_t;

    typedef enum logic [1:0] {
        groups_1 = 2'd0,
        groups_2 = 2'd1,
        groups_4 = 2'd2
    } lane_cfg_t;

    // registers per operand, code 3 counts as four
    function automatic cnt_t reg_count(input lmul_t lmul);
        case (lmul)
            lmul_1:  return 3'd1;
            lmul_2:  return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // active lane groups, code 3 counts as four
    function automatic cnt_t group_count(input lane_cfg_t cfg);
        case (cfg)
            groups_1: return 3'd1;
            groups_2: return 3'd2;
            default:  return 3'd4;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: hdl/valu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module valu_sequencer import valu_pkg::*; (
    input  logic      valu_clk,
    input  logic      rst,
    input  logic      start,
    input  alu_op_t   op,
    input  sew_t      sew,
    input  lmul_t     lmul,
    input  lane_cfg_t lane_cfg,
    output logic      cap_en,
    output logic      clear,
    output logic      issue_valid,
    output pass_t     issue_pass,
    output lane_cfg_t issue_groups,
    output alu_op_t   alu_op,
    output sew_t      alu_sew,
    output logic      done
);

    typedef enum logic [1:0] {
        s_idle,
        s_issue,
        s_drain
    } state_t;

    state_t state;
    pass_t  pass_cnt;
    pass_t  last_pass;
    logic   last_issue;
    logic   last_d1;

    // a start is only taken while idle
    assign cap_en = start && (state == s_idle);
    assign clear  = cap_en;

    ////////////////////////////////////////////////////////////
    // command capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge valu_clk) begin
        if (cap_en) begin : capture
            int regs;
            int grps;
            regs = int'(reg_count(lmul));
            grps = int'(group_count(lane_cfg));
            alu_op       <= op;
            alu_sew      <= sew;
            issue_groups <= lane_cfg;
            // passes = ceil(regs / grps), keep the last index
            last_pass    <= pass_t'((regs + grps - 1) / grps - 1);
        end
    end

    ////////////////////////////////////////////////////////////
    // pass issue and done timing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge valu_clk) begin
        if (rst) begin
            state       <= s_idle;
            pass_cnt    <= '0;
            issue_valid <= 1'b0;
            issue_pass  <= '0;
            last_issue  <= 1'b0;
            last_d1     <= 1'b0;
            done        <= 1'b0;
        end else begin
            issue_valid <= 1'b0;
            last_issue  <= 1'b0;
            // one cycle in the lane ALU, one in the collector
            last_d1     <= last_issue;
            done        <= last_d1;

            case (state)
                s_idle: begin
                    if (start) begin
                        pass_cnt <= '0;
                        state    <= s_issue;
                    end
                end
                s_issue: begin
                    issue_valid <= 1'b1;
                    issue_pass  <= pass_cnt;
                    pass_cnt    <= pass_cnt + 2'd1;
                    if (pass_cnt == last_pass) begin
                        last_issue <= 1'b1;
                        state      <= s_drain;
                    end
                end
                s_drain: begin
                    // back to idle in the same edge that raises done
                    if (last_d1) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select import valu_pkg::*; #(
    parameter int NUM_GROUPS = 4
) (
    input  logic                  valu_clk,
    input  logic                  rst,
    input  logic                  cap_en,
    input  reg_group_t            src_a,
    input  reg_group_t            src_b,
    input  pass_t                 issue_pass,
    input  lane_cfg_t             issue_groups,
    output reg_t [NUM_GROUPS-1:0] lane_a,
    output reg_t [NUM_GROUPS-1:0] lane_b
);

    reg_group_t grp_a;
    reg_group_t grp_b;

    // operand groups held for the whole command
    always_ff @(posedge valu_clk) begin
        if (rst) begin
            grp_a <= '0;
            grp_b <= '0;
        end else if (cap_en) begin
            grp_a <= src_a;
            grp_b <= src_b;
        end
    end

    ////////////////////////////////////////////////////////////
    // register r goes to group r mod G in pass r / G
    ////////////////////////////////////////////////////////////

    always_comb begin : route
        cnt_t       active;
        logic [3:0] idx;
        reg_idx_t   slot;
        active = group_count(issue_groups);
        for (int g = 0; g < NUM_GROUPS; g++) begin
            idx  = 4'(issue_pass) * 4'(active) + 4'(g);
            slot = reg_idx_t'(idx);
            // idle groups and indices past the group get zero
            if (g < int'(active) && idx < 4'(MAX_REGS)) begin
                lane_a[g] = grp_a[slot*VLEN_BITS +: VLEN_BITS];
                lane_b[g] = grp_b[slot*VLEN_BITS +: VLEN_BITS];
            end else begin
                lane_a[g] = '0;
                lane_b[g] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/lane_alu.sv
`timescale 1ns/1ps
`default_nettype none

module lane_alu import valu_pkg::*; #(
    parameter int LANE_BITS = 32
) (
    input  logic    valu_clk,
    input  logic    rst,
    input  alu_op_t alu_op,
    input  sew_t    alu_sew,
    input  reg_t    lane_a,
    input  reg_t    lane_b,
    output reg_t    lane_result
);

    localparam int NUM_LANES = VLEN_BITS / LANE_BITS;

    reg_t lane_next;

    ////////////////////////////////////////////////////////////
    // one element of width w in a 32 bit container
    ////////////////////////////////////////////////////////////

    // caller keeps the low w bits of the return value
    function automatic elem_t elem_op(input alu_op_t op, input elem_t a, input elem_t b,
                                      input int w);
        elem_t      mask;
        elem_t      a_u;
        elem_t      b_u;
        elem_t      a_s;
        elem_t      b_s;
        elem_t      res;
        logic [4:0] sh;
        mask = (w >= ELEM_MAX_BITS) ? '1 : ((elem_t'(1) << w) - elem_t'(1));
        a_u  = a & mask;
        b_u  = b & mask;
        // sign extension from bit w-1
        a_s  = elem_t'($signed(a_u << (ELEM_MAX_BITS - w)) >>> (ELEM_MAX_BITS - w));
        b_s  = elem_t'($signed(b_u << (ELEM_MAX_BITS - w)) >>> (ELEM_MAX_BITS - w));
        // shift amount masked to the element width
        sh   = b_u[4:0] & 5'(w - 1);
        case (op)
            op_add:  res = a_u + b_u;
            op_sub:  res = a_u - b_u;
            op_and:  res = a_u & b_u;
            op_or:   res = a_u | b_u;
            op_xor:  res = a_u ^ b_u;
            op_sll:  res = a_u << sh;
            op_srl:  res = a_u >> sh;
            op_sra:  res = $signed(a_s) >>> sh;
            op_min:  res = ($signed(a_s) < $signed(b_s)) ? a_u : b_u;
            op_max:  res = ($signed(a_s) < $signed(b_s)) ? b_u : a_u;
            op_minu: res = (a_u < b_u) ? a_u : b_u;
            op_maxu: res = (a_u < b_u) ? b_u : a_u;
            // unused codes
            default: res = '0;
        endcase
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // lanes, each computed at all three widths
    ////////////////////////////////////////////////////////////

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        logic [LANE_BITS-1:0] r8;
        logic [LANE_BITS-1:0] r16;
        logic [LANE_BITS-1:0] r32;

        always_comb begin : elems
            elem_t t;
            r8  = '0;
            r16 = '0;
            r32 = '0;
            for (int e = 0; e < LANE_BITS / 8; e++) begin
                t = elem_op(alu_op, elem_t'(lane_a[l*LANE_BITS + e*8 +: 8]),
                            elem_t'(lane_b[l*LANE_BITS + e*8 +: 8]), 8);
                r8[e*8 +: 8] = t[7:0];
            end
            for (int e = 0; e < LANE_BITS / 16; e++) begin
                t = elem_op(alu_op, elem_t'(lane_a[l*LANE_BITS + e*16 +: 16]),
                            elem_t'(lane_b[l*LANE_BITS + e*16 +: 16]), 16);
                r16[e*16 +: 16] = t[15:0];
            end
            for (int e = 0; e < LANE_BITS / 32; e++) begin
                t = elem_op(alu_op, elem_t'(lane_a[l*LANE_BITS + e*32 +: 32]),
                            elem_t'(lane_b[l*LANE_BITS + e*32 +: 32]), 32);
                r32[e*32 +: 32] = t;
            end
        end

        // code 3 falls through to 32 bit elements
        assign lane_next[l*LANE_BITS +: LANE_BITS] = (alu_sew == sew_8)  ? r8  :
                                                     (alu_sew == sew_16) ? r16 : r32;
    end

    always_ff @(posedge valu_clk) begin
        if (rst) begin
            lane_result <= '0;
        end else begin
            lane_result <= lane_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/result_collect.sv
`timescale 1ns/1ps
`default_nettype none

module result_collect import valu_pkg::*; #(
    parameter int NUM_GROUPS = 4
) (
    input  logic                  valu_clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  issue_valid,
    input  pass_t                 issue_pass,
    input  lane_cfg_t             issue_groups,
    input  lmul_t                 lmul,
    input  reg_t [NUM_GROUPS-1:0] lane_result,
    output reg_group_t            result
);

    logic  valid_d;
    pass_t pass_d;
    cnt_t  regs_q;

    ////////////////////////////////////////////////////////////
    // pass alignment with the lane ALU register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge valu_clk) begin
        if (rst) begin
            valid_d <= 1'b0;
            pass_d  <= '0;
        end else begin
            valid_d <= issue_valid;
            pass_d  <= issue_pass;
        end
    end

    ////////////////////////////////////////////////////////////
    // result register group
    ////////////////////////////////////////////////////////////

    always_ff @(posedge valu_clk) begin : collect
        cnt_t       active;
        logic [3:0] idx;
        reg_idx_t   slot;
        active = group_count(issue_groups);
        if (rst) begin
            regs_q <= '0;
            result <= '0;
        end else if (clear) begin
            // register count taken with the command
            regs_q <= reg_count(lmul);
            result <= '0;
        end else if (valid_d) begin
            for (int g = 0; g < NUM_GROUPS; g++) begin
                idx  = 4'(pass_d) * 4'(active) + 4'(g);
                slot = reg_idx_t'(idx);
                // slots past the count stay cleared
                if (g < int'(active) && idx < 4'(regs_q)) begin
                    result[slot*VLEN_BITS +: VLEN_BITS] <= lane_result[g];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/valu_top.sv
`timescale 1ns/1ps
`default_nettype none

module valu_top import valu_pkg::*; #(
    parameter int NUM_GROUPS = 4,
    parameter int LANE_BITS  = 32
) (
    input  logic       valu_clk,
    input  logic       rst,
    input  logic       start,
    input  alu_op_t    op,
    input  sew_t       sew,
    input  lmul_t      lmul,
    input  lane_cfg_t  lane_cfg,
    input  reg_group_t src_a,
    input  reg_group_t src_b,
    output reg_group_t result,
    output logic       done
);

    logic                  cap_en;
    logic                  clear;
    logic                  issue_valid;
    pass_t                 issue_pass;
    lane_cfg_t             issue_groups;
    alu_op_t               alu_op;
    sew_t                  alu_sew;
    reg_t [NUM_GROUPS-1:0] lane_a;
    reg_t [NUM_GROUPS-1:0] lane_b;
    reg_t [NUM_GROUPS-1:0] lane_result;

    ////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////

    valu_sequencer u_seq (
        .valu_clk     (valu_clk),
        .rst          (rst),
        .start        (start),
        .op           (op),
        .sew          (sew),
        .lmul         (lmul),
        .lane_cfg     (lane_cfg),
        .cap_en       (cap_en),
        .clear        (clear),
        .issue_valid  (issue_valid),
        .issue_pass   (issue_pass),
        .issue_groups (issue_groups),
        .alu_op       (alu_op),
        .alu_sew      (alu_sew),
        .done         (done)
    );

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    operand_select #(
        .NUM_GROUPS (NUM_GROUPS)
    ) u_opsel (
        .valu_clk     (valu_clk),
        .rst          (rst),
        .cap_en       (cap_en),
        .src_a        (src_a),
        .src_b        (src_b),
        .issue_pass   (issue_pass),
        .issue_groups (issue_groups),
        .lane_a       (lane_a),
        .lane_b       (lane_b)
    );

    // one ALU per lane group
    for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_alu
        lane_alu #(
            .LANE_BITS (LANE_BITS)
        ) u_alu (
            .valu_clk    (valu_clk),
            .rst         (rst),
            .alu_op      (alu_op),
            .alu_sew     (alu_sew),
            .lane_a      (lane_a[g]),
            .lane_b      (lane_b[g]),
            .lane_result (lane_result[g])
        );
    end

    result_collect #(
        .NUM_GROUPS (NUM_GROUPS)
    ) u_collect (
        .valu_clk     (valu_clk),
        .rst          (rst),
        .clear        (clear),
        .issue_valid  (issue_valid),
        .issue_pass   (issue_pass),
        .issue_groups (issue_groups),
        .lmul         (lmul),
        .lane_result  (lane_result),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: include/valu_tb_ref.svh
`ifndef VALU_TB_REF_SVH
`define VALU_TB_REF_SVH

// expected result group, one element at a time
function automatic reg_group_t ref_result(input alu_op_t f_op, input sew_t f_sew,
                                          input lmul_t f_lmul, input reg_group_t a,
                                          input reg_group_t b);
    reg_group_t      res;
    int              w;
    int              regs;
    int              sh;
    longint unsigned mask;
    longint unsigned ua;
    longint unsigned ub;
    longint unsigned r;
    longint          sa;
    longint          sb;
    res = '0;
    case (f_sew)
        sew_8:   w = 8;
        sew_16:  w = 16;
        default: w = 32;
    endcase
    case (f_lmul)
        lmul_1:  regs = 1;
        lmul_2:  regs = 2;
        default: regs = 4;
    endcase
    mask = (64'd1 << w) - 64'd1;
    // slices past the register count are never written
    for (int e = 0; e < regs * VLEN_BITS / w; e++) begin
        ua = 64'(a >> (e * w)) & mask;
        ub = 64'(b >> (e * w)) & mask;
        // two's complement value of each element
        sa = ua[w-1] ? (longint'(ua) - (64'sd1 << w)) : longint'(ua);
        sb = ub[w-1] ? (longint'(ub) - (64'sd1 << w)) : longint'(ub);
        sh = int'(ub) & (w - 1);
        case (f_op)
            op_add:  r = ua + ub;
            op_sub:  r = ua - ub;
            op_and:  r = ua & ub;
            op_or:   r = ua | ub;
            op_xor:  r = ua ^ ub;
            op_sll:  r = ua << sh;
            op_srl:  r = ua >> sh;
            op_sra:  r = $unsigned(sa >>> sh);
            op_min:  r = (sa < sb) ? ua : ub;
            op_max:  r = (sa > sb) ? ua : ub;
            op_minu: r = (ua < ub) ? ua : ub;
            op_maxu: r = (ua > ub) ? ua : ub;
            default: r = '0;
        endcase
        res = res | (reg_group_t'(r & mask) << (e * w));
    end
    return res;
endfunction

`endif

// File: verification/valu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module valu_tb import valu_pkg::*; ();

    ////////////////////////////////////////////////////////////
    // run length
    ////////////////////////////////////////////////////////////

    // commands over all six tests
    localparam int NUM_CMDS       = 1 + 36 + 36 + 3 + 16 + 40;
    // start edge, up to four passes, lane and collect stages, idle cycle
    localparam int CMD_CYCLES     = 1 + 4 + 2 + 1;
    // reset, quiet window after the dropped start, margin
    localparam int TIMEOUT_CYCLES = NUM_CMDS * CMD_CYCLES + 4 + 8 + 20;

    logic       valu_clk;
    logic       rst;
    logic       start;
    alu_op_t    op;
    sew_t       sew;
    lmul_t      lmul;
    lane_cfg_t  lane_cfg;
    reg_group_t src_a;
    reg_group_t src_b;
    reg_group_t result;
    logic       done;

    int         seed;
    int         cycle_cnt;
    int         checks;
    int         errors;
    int         test_num;
    int         test_checks0;
    int         test_errors0;
    // one expected result and due cycle per accepted start
    reg_group_t exp_q[$];
    int         due_q[$];

    alu_op_t    arith_ops[6] = '{op_add, op_sub, op_min, op_max, op_minu, op_maxu};
    alu_op_t    logic_ops[6] = '{op_and, op_or, op_xor, op_sll, op_srl, op_sra};

    `include "valu_tb_ref.svh"

    valu_top #(
        .NUM_GROUPS (4),
        .LANE_BITS  (32)
    ) u_dut (
        .valu_clk (valu_clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .sew      (sew),
        .lmul     (lmul),
        .lane_cfg (lane_cfg),
        .src_a    (src_a),
        .src_b    (src_b),
        .result   (result),
        .done     (done)
    );

    initial valu_clk = 1'b0;
    always #2 valu_clk = ~valu_clk;

    always @(posedge valu_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // ceil(registers / active groups)
    function automatic int count_passes(input lmul_t c_lmul, input lane_cfg_t c_cfg);
        int regs;
        int grps;
        regs = (c_lmul == lmul_1) ? 1 : (c_lmul == lmul_2) ? 2 : 4;
        grps = (c_cfg == groups_1) ? 1 : (c_cfg == groups_2) ? 2 : 4;
        return (regs + grps - 1) / grps;
    endfunction

    function automatic reg_group_t random_group();
        reg_group_t g;
        for (int i = 0; i < MAX_REGS * VLEN_BITS / 32; i++) begin
            g[i*32 +: 32] = $random(seed);
        end
        return g;
    endfunction

    task automatic issue_cmd(input alu_op_t c_op, input sew_t c_sew, input lmul_t c_lmul,
                             input lane_cfg_t c_cfg, input reg_group_t a,
                             input reg_group_t b, output int due);
        @(negedge valu_clk);
        start    = 1'b1;
        op       = c_op;
        sew      = c_sew;
        lmul     = c_lmul;
        lane_cfg = c_cfg;
        src_a    = a;
        src_b    = b;
        exp_q.push_back(ref_result(c_op, c_sew, c_lmul, a, b));
        // start edge, P issue edges, then two more
        due = cycle_cnt + count_passes(c_lmul, c_cfg) + 3;
        due_q.push_back(due);
        @(negedge valu_clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input int due);
        while (!done && cycle_cnt < due) begin
            @(negedge valu_clk);
        end
        if (!done) begin
            $display("[%0t] done did not arrive by cycle %0d", $time, due);
            errors++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic run_cmd(input alu_op_t c_op, input sew_t c_sew, input lmul_t c_lmul,
                           input lane_cfg_t c_cfg, input reg_group_t a, input reg_group_t b);
        int due;
        issue_cmd(c_op, c_sew, c_lmul, c_cfg, a, b, due);
        wait_done(due);
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 checks - test_checks0, errors - test_errors0);
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // compare on every done
    ////////////////////////////////////////////////////////////

    always @(negedge valu_clk) begin : compare
        reg_group_t expected;
        int         due;
        if (!rst && done) begin
            if (exp_q.size() == 0) begin
                $display("[%0t] done pulse with no command outstanding", $time);
                errors++;
            end else begin
                expected = exp_q.pop_front();
                due      = due_q.pop_front();
                checks++;
                if (result !== expected) begin
                    $display("[FAIL] %0t result expected %h got %h", $time, expected, result);
                    errors++;
                end
                if (cycle_cnt != due) begin
                    $display("[%0t] done came at cycle %0d instead of cycle %0d",
                             $time, cycle_cnt, due);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    initial begin : main
        int          due;
        logic [31:0] r;
        reg_group_t  a;
        reg_group_t  b;
        seed         = 40528;
        checks       = 0;
        errors       = 0;
        test_num     = 0;
        test_checks0 = 0;
        test_errors0 = 0;
        rst          = 1'b1;
        start        = 1'b0;
        op           = op_add;
        sew          = sew_8;
        lmul         = lmul_1;
        lane_cfg     = groups_1;
        src_a        = '0;
        src_b        = '0;
        repeat (4) @(negedge valu_clk);
        rst = 1'b0;

        // reset state and a start while busy
        @(negedge valu_clk);
        checks += 2;
        if (done !== 1'b0) begin
            $display("[FAIL] %0t done expected 0 got %b", $time, done);
            errors++;
        end
        if (result !== '0) begin
            $display("[FAIL] %0t result expected 0 got %h", $time, result);
            errors++;
        end
        a = random_group();
        b = random_group();
        issue_cmd(op_add, sew_16, lmul_4, groups_1, a, b, due);
        start = 1'b1;
        op    = op_xor;
        src_a = random_group();
        src_b = random_group();
        @(negedge valu_clk);
        start = 1'b0;
        wait_done(due);
        // any done in this quiet window is extra
        repeat (8) @(negedge valu_clk);
        report_test("reset and ignored start");

        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < 6; i++) begin
                // every element overflows with its sign bit set
                run_cmd(arith_ops[i], sew_t'(2'(s)), lmul_4, groups_4,
                        {16{32'h807F_FF80}}, {16{32'hFF81_0180}});
                run_cmd(arith_ops[i], sew_t'(2'(s)), lmul_4, groups_4,
                        random_group(), random_group());
            end
        end
        report_test("element arithmetic");

        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < 6; i++) begin
                // amounts at and above the element width
                run_cmd(logic_ops[i], sew_t'(2'(s)), lmul_4, groups_4,
                        {16{32'hF0C3_8001}}, {16{32'h2720_1F08}});
                run_cmd(logic_ops[i], sew_t'(2'(s)), lmul_4, groups_4,
                        random_group(), random_group());
            end
        end
        report_test("logic and shifts");

        for (int m = 0; m < 3; m++) begin
            run_cmd(op_sub, sew_32, lmul_t'(2'(m)), groups_4, random_group(), random_group());
        end
        report_test("register grouping");

        // code 3 included for both fields
        for (int c = 0; c < 4; c++) begin
            for (int m = 0; m < 4; m++) begin
                r = $random(seed);
                run_cmd(alu_op_t'(4'(r[7:0] % 8'd12)), sew_t'(r[9:8]), lmul_t'(2'(m)),
                        lane_cfg_t'(2'(c)), random_group(), random_group());
            end
        end
        report_test("lane configuration");

        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            run_cmd(alu_op_t'(4'(r[7:0] % 8'd12)), sew_t'(r[9:8]), lmul_t'(r[11:10]),
                    lane_cfg_t'(r[13:12]), random_group(), random_group());
        end
        report_test("random commands");

        $display("tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
hdl/valu_pkg.sv
hdl/valu_sequencer.sv
hdl/operand_select.sv
hdl/lane_alu.sv
hdl/result_collect.sv
hdl/valu_top.sv
verification/valu_tb.sv

// File: Makefile
TOOL       := verilator
TOP        := valu_tb
FILELIST   := compile.f
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
